// File: dotPkg.sv
`default_nettype none

package dotPkg;

  // ##########################################################################
  // Lane and row geometry
  // ##########################################################################

  localparam int LANE_BITS = 8;                      // Width of one lane.
  localparam int LANES = 4;                          // Lanes per wide row.
  localparam int LANE_SEL_BITS = $clog2(LANES);      // Low load address bits pick the lane.

  // Four signed 16-bit products need two more bits for the sum.
  localparam int RESULT_BITS = 18;

  // ##########################################################################
  // Lane decoding
  // ##########################################################################

  // One stored lane, seen as a signed weight or as an unsigned pixel.
  typedef union packed {
    logic signed [LANE_BITS-1:0] weight;             // Signed coefficient.
    logic [LANE_BITS-1:0] pixel;                     // Unsigned sample.
  } laneWord_u;

  // Load target select.
  localparam logic TARGET_WEIGHT = 1'b0;
  localparam logic TARGET_PIXEL = 1'b1;

endpackage

`default_nettype wire

// File: asymRamReadWide.sv
`timescale 1ns/1ps
`default_nettype none

module asymRamReadWide import dotPkg::*; #(
  parameter int ROWS = 16,
  parameter int LATENCY = 1
) (
  input  logic clkA,
  input  logic arstN,
  input  logic wrEn,
  input  logic [$clog2(ROWS)+LANE_SEL_BITS-1:0] wrAddr,
  input  logic [LANE_BITS-1:0] wrData,
  input  logic rdEn,
  input  logic [$clog2(ROWS)-1:0] rdRow,
  output logic [LANES*LANE_BITS-1:0] rdData
);

  localparam int ROW_BITS = $clog2(ROWS);
  localparam int ROW_WIDTH = LANES * LANE_BITS;

  logic [ROW_WIDTH-1:0] mem [ROWS];
  logic [ROW_BITS-1:0] wrRow;
  logic [LANE_SEL_BITS-1:0] wrLane;
  logic [LANES-1:0] laneMask;
  logic [ROW_WIDTH-1:0] firstStage;

  // ##########################################################################
  // Narrow write port
  // ##########################################################################

  assign wrRow = wrAddr[ROW_BITS+LANE_SEL_BITS-1:LANE_SEL_BITS];  // Row number.
  assign wrLane = wrAddr[LANE_SEL_BITS-1:0];                       // Lane within the row.

  always_comb begin
    laneMask = '0;
    laneMask[wrLane] = wrEn;                         // One lane enabled per write.
  end

  initial begin
    for (int row = 0; row < ROWS; row++) begin
      mem[row] = '0;                                 // Unloaded rows read as zero.
    end
  end

  // Only the masked lane changes, the rest of the row keeps its contents.
  always_ff @(posedge clkA) begin
    for (int lane = 0; lane < LANES; lane++) begin
      if (laneMask[lane]) begin
        mem[wrRow][lane*LANE_BITS +: LANE_BITS] <= wrData;
      end
    end
  end

  // ##########################################################################
  // Wide read port and latency pipeline
  // ##########################################################################

  always_ff @(posedge clkA) begin
    if (rdEn) begin
      firstStage <= mem[rdRow];                      // Registered RAM output.
    end
  end

  generate
    if (LATENCY > 1) begin : gDelay
      logic [LATENCY-2:0] advance;                   // Read enable, delayed per stage.
      logic [ROW_WIDTH-1:0] delayStage [LATENCY-1];

      always_ff @(posedge clkA or negedge arstN) begin
        if (!arstN) begin
          advance <= '0;
          for (int stage = 0; stage < LATENCY - 1; stage++) begin
            delayStage[stage] <= '0;
          end
        end else begin
          advance[0] <= rdEn;
          for (int stage = 1; stage < LATENCY - 1; stage++) begin
            advance[stage] <= advance[stage-1];
          end
          if (advance[0]) begin
            delayStage[0] <= firstStage;
          end
          for (int stage = 1; stage < LATENCY - 1; stage++) begin
            if (advance[stage]) begin
              delayStage[stage] <= delayStage[stage-1];
            end
          end
        end
      end

      assign rdData = delayStage[LATENCY-2];         // Row appears LATENCY cycles after rdEn.
    end else begin : gDirect
      assign rdData = firstStage;
    end
  endgenerate

endmodule

`default_nettype wire

// File: dotCombiner.sv
`timescale 1ns/1ps
`default_nettype none

module dotCombiner import dotPkg::*; #(
  parameter int W_LATENCY = 2,
  parameter int P_LATENCY = 1
) (
  input  logic clkA,
  input  logic arstN,
  input  logic rdEn,
  input  logic [LANES*LANE_BITS-1:0] weightRow,
  input  logic [LANES*LANE_BITS-1:0] pixelRow,
  output logic resultValid,
  output logic signed [RESULT_BITS-1:0] resultData
);

  localparam int ROW_WIDTH = LANES * LANE_BITS;
  localparam int PROD_BITS = 2 * LANE_BITS;
  localparam int MAX_LAT = (W_LATENCY > P_LATENCY) ? W_LATENCY : P_LATENCY;
  localparam int SKEW = (W_LATENCY > P_LATENCY) ? (W_LATENCY - P_LATENCY)
                                                : (P_LATENCY - W_LATENCY);

  logic [MAX_LAT+1:0] validPipe;
  logic [ROW_WIDTH-1:0] weightAligned;
  logic [ROW_WIDTH-1:0] pixelAligned;
  laneWord_u weightLane [LANES];
  laneWord_u pixelLane [LANES];
  logic signed [PROD_BITS-1:0] product [LANES];
  logic signed [RESULT_BITS-1:0] sumNext;

  // ##########################################################################
  // Bank alignment
  // ##########################################################################

  generate
    if (SKEW == 0) begin : gNoSkew
      assign weightAligned = weightRow;
      assign pixelAligned = pixelRow;
    end else begin : gSkew
      logic [ROW_WIDTH-1:0] fastRow;
      logic [ROW_WIDTH-1:0] skewStage [SKEW];

      assign fastRow = (W_LATENCY < P_LATENCY) ? weightRow : pixelRow;  // Earlier bank.

      always_ff @(posedge clkA or negedge arstN) begin
        if (!arstN) begin
          for (int stage = 0; stage < SKEW; stage++) begin
            skewStage[stage] <= '0;
          end
        end else begin
          skewStage[0] <= fastRow;
          for (int stage = 1; stage < SKEW; stage++) begin
            skewStage[stage] <= skewStage[stage-1];
          end
        end
      end

      if (W_LATENCY < P_LATENCY) begin : gDelayWeight
        assign weightAligned = skewStage[SKEW-1];
        assign pixelAligned = pixelRow;
      end else begin : gDelayPixel
        assign weightAligned = weightRow;
        assign pixelAligned = skewStage[SKEW-1];
      end
    end
  endgenerate

  // ##########################################################################
  // Multiply and sum
  // ##########################################################################

  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      weightLane[lane] = weightAligned[lane*LANE_BITS +: LANE_BITS];
      pixelLane[lane] = pixelAligned[lane*LANE_BITS +: LANE_BITS];
    end
  end

  // Pixels get a zero sign bit so the product stays signed.
  always_ff @(posedge clkA) begin
    if (validPipe[MAX_LAT-1]) begin
      for (int lane = 0; lane < LANES; lane++) begin
        product[lane] <= weightLane[lane].weight * $signed({1'b0, pixelLane[lane].pixel});
      end
    end
  end

  always_comb begin
    sumNext = '0;
    for (int lane = 0; lane < LANES; lane++) begin
      sumNext = sumNext + RESULT_BITS'(product[lane]);  // Sign-extended before adding.
    end
  end

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      validPipe <= '0;
      resultData <= '0;
    end else begin
      validPipe <= {validPipe[MAX_LAT:0], rdEn};       // Tracks the read through both banks.
      if (validPipe[MAX_LAT]) begin
        resultData <= sumNext;
      end
    end
  end

  assign resultValid = validPipe[MAX_LAT+1];          // One cycle per read.

endmodule

`default_nettype wire

// File: requestControl.sv
`timescale 1ns/1ps
`default_nettype none

module requestControl import dotPkg::*; (
  input  logic clkA,
  input  logic arstN,
  input  logic loadValid,
  input  logic loadTarget,
  output logic loadReady,
  output logic weightWrEn,
  output logic pixelWrEn,
  input  logic req,
  output logic ack,
  output logic rdEn,
  input  logic resultValid,
  input  logic signed [RESULT_BITS-1:0] resultData,
  output logic signed [RESULT_BITS-1:0] resultHeld
);

  localparam logic [1:0] STATE_IDLE = 2'd0;
  localparam logic [1:0] STATE_READING = 2'd1;
  localparam logic [1:0] STATE_ACKING = 2'd2;
  localparam logic [1:0] STATE_RELEASING = 2'd3;

  logic [1:0] state;
  logic [1:0] stateNext;
  logic loadAccept;
  logic issueRead;

  // ##########################################################################
  // Load gating
  // ##########################################################################

  // Loads are taken only while nothing is requested or in flight.
  assign loadReady = (state == STATE_IDLE) && !req && !ack;
  assign loadAccept = loadValid && loadReady;

  assign weightWrEn = loadAccept && (loadTarget == TARGET_WEIGHT);
  assign pixelWrEn = loadAccept && (loadTarget == TARGET_PIXEL);

  // ##########################################################################
  // Request FSM
  // ##########################################################################

  assign issueRead = (state == STATE_IDLE) && req;

  always_comb begin
    stateNext = state;
    case (state)
      STATE_IDLE: begin
        if (req) begin
          stateNext = STATE_READING;
        end
      end
      STATE_READING: begin
        if (resultValid) begin
          stateNext = STATE_ACKING;                  // Result captured at this edge.
        end
      end
      STATE_ACKING: begin
        if (!req) begin
          stateNext = STATE_RELEASING;
        end
      end
      default: begin
        stateNext = STATE_IDLE;                      // One idle cycle after ack falls.
      end
    endcase
  end

  always_ff @(posedge clkA or negedge arstN) begin
    if (!arstN) begin
      state <= STATE_IDLE;
      rdEn <= 1'b0;
      resultHeld <= '0;
    end else begin
      state <= stateNext;
      rdEn <= issueRead;                             // Single-cycle pulse to both banks.
      if ((state == STATE_READING) && resultValid) begin
        resultHeld <= resultData;
      end
    end
  end

  // Held high until the host drops req.
  assign ack = (state == STATE_ACKING);

endmodule

`default_nettype wire

// File: dotEngine.sv
`timescale 1ns/1ps
`default_nettype none

module dotEngine import dotPkg::*; #(
  parameter int ROWS = 16,
  parameter int W_LATENCY = 2,
  parameter int P_LATENCY = 1
) (
  input  logic clkA,
  input  logic arstN,
  input  logic loadValid,
  input  logic loadTarget,
  input  logic [$clog2(ROWS)+LANE_SEL_BITS-1:0] loadAddr,
  input  logic [LANE_BITS-1:0] loadData,
  output logic loadReady,
  input  logic req,
  input  logic [$clog2(ROWS)-1:0] rowW,
  input  logic [$clog2(ROWS)-1:0] rowP,
  output logic ack,
  output logic signed [RESULT_BITS-1:0] resultData
);

  localparam int ROW_WIDTH = LANES * LANE_BITS;

  logic weightWrEn;
  logic pixelWrEn;
  logic rdEn;
  logic [ROW_WIDTH-1:0] weightRow;
  logic [ROW_WIDTH-1:0] pixelRow;
  logic combValid;
  logic signed [RESULT_BITS-1:0] combData;

  // ##########################################################################
  // Control
  // ##########################################################################

  requestControl requestControl_inst (
    .clkA        (clkA),
    .arstN       (arstN),
    .loadValid   (loadValid),
    .loadTarget  (loadTarget),
    .loadReady   (loadReady),
    .weightWrEn  (weightWrEn),
    .pixelWrEn   (pixelWrEn),
    .req         (req),
    .ack         (ack),
    .rdEn        (rdEn),
    .resultValid (combValid),
    .resultData  (combData),
    .resultHeld  (resultData)
  );

  // ##########################################################################
  // Banks
  // ##########################################################################

  asymRamReadWide #(
    .ROWS    (ROWS),
    .LATENCY (W_LATENCY)
  ) weightBank (
    .clkA   (clkA),
    .arstN  (arstN),
    .wrEn   (weightWrEn),
    .wrAddr (loadAddr),
    .wrData (loadData),
    .rdEn   (rdEn),
    .rdRow  (rowW),
    .rdData (weightRow)
  );

  asymRamReadWide #(
    .ROWS    (ROWS),
    .LATENCY (P_LATENCY)
  ) pixelBank (
    .clkA   (clkA),
    .arstN  (arstN),
    .wrEn   (pixelWrEn),
    .wrAddr (loadAddr),
    .wrData (loadData),
    .rdEn   (rdEn),
    .rdRow  (rowP),
    .rdData (pixelRow)
  );

  // ##########################################################################
  // Dot product
  // ##########################################################################

  dotCombiner #(
    .W_LATENCY (W_LATENCY),
    .P_LATENCY (P_LATENCY)
  ) dotCombiner_inst (
    .clkA        (clkA),
    .arstN       (arstN),
    .rdEn        (rdEn),
    .weightRow   (weightRow),
    .pixelRow    (pixelRow),
    .resultValid (combValid),
    .resultData  (combData)
  );

endmodule

`default_nettype wire

// File: dotEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

module dotEngineTb import dotPkg::*; ();

  localparam int ROWS = 16;
  localparam int ROW_BITS = $clog2(ROWS);
  localparam int ADDR_BITS = ROW_BITS + LANE_SEL_BITS;
  localparam int NUM_RANDOM_REQ = 24;
  localparam int NUM_LOADS = 2 * ROWS * LANES + 16 + 1 + 4;
  localparam int NUM_REQUESTS = 1 + NUM_RANDOM_REQ + 3 + 2 + 2 + 4;
  localparam int CYCLE_LIMIT = 2 * (NUM_LOADS + 12 * NUM_REQUESTS);

  logic clkA;
  logic arstN;
  logic loadValid;
  logic loadTarget;
  logic [ADDR_BITS-1:0] loadAddr;
  logic [LANE_BITS-1:0] loadData;
  logic loadReady;
  logic req;
  logic [ROW_BITS-1:0] rowW;
  logic [ROW_BITS-1:0] rowP;
  logic ack;
  logic signed [RESULT_BITS-1:0] resultData;

  logic [LANE_BITS-1:0] shadowW [ROWS][LANES];
  logic [LANE_BITS-1:0] shadowP [ROWS][LANES];
  logic signed [RESULT_BITS-1:0] expectedQ [$];
  logic signed [RESULT_BITS-1:0] requestExpected;
  int cycleCount;

  dotEngine #(.ROWS(ROWS)) dotEngine_inst (
    .clkA       (clkA),
    .arstN      (arstN),
    .loadValid  (loadValid),
    .loadTarget (loadTarget),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .loadReady  (loadReady),
    .req        (req),
    .rowW       (rowW),
    .rowP       (rowP),
    .ack        (ack),
    .resultData (resultData)
  );

  initial begin
    clkA = 1'b0;
    forever #10 clkA = ~clkA;
  end

  // ##########################################################################
  // Reference model and checks
  // ##########################################################################

  function automatic logic signed [RESULT_BITS-1:0] refDot(input int rw, input int rp);
    laneWord_u w;
    laneWord_u p;
    int sum;
    sum = 0;
    for (int lane = 0; lane < LANES; lane++) begin
      w = shadowW[rw][lane];
      p = shadowP[rp][lane];
      sum += int'(w.weight) * int'(p.pixel);         // Signed weight times unsigned pixel.
    end
    return RESULT_BITS'(sum);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s actual 0x%h expected 0x%h", name, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  initial begin : resultChecker
    logic ackPrev;
    logic signed [RESULT_BITS-1:0] expected;
    ackPrev = 1'b0;
    forever begin
      @(negedge clkA);
      if (ack && !ackPrev) begin
        if (expectedQ.size() == 0) begin
          $display("ack rose although no request was outstanding");
          $display("Test failures found");
          $fatal(1);
        end
        expected = expectedQ.pop_front();
        checkValue("resultData", resultData, expected);
      end
      ackPrev = ack;
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    forever begin
      @(posedge clkA);
      cycleCount++;
      if (cycleCount >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
        $display("Test failures found");
        $fatal(1);
      end
    end
  end

  // ##########################################################################
  // Host tasks
  // ##########################################################################

  // Waits for loadReady, so the word is always taken.
  task automatic writeLane(input logic target, input int row, input int lane,
                           input logic [LANE_BITS-1:0] data);
    @(negedge clkA);
    loadValid = 1'b1;
    loadTarget = target;
    loadAddr = ADDR_BITS'(row * LANES + lane);
    loadData = data;
    #1;
    while (!loadReady) begin
      @(negedge clkA);
      #1;
    end
    if (target == TARGET_WEIGHT) shadowW[row][lane] = data;
    else shadowP[row][lane] = data;
  endtask

  // Offered once while busy and expected to be dropped.
  task automatic offerLoad(input logic target, input int row, input int lane,
                           input logic [LANE_BITS-1:0] data);
    @(negedge clkA);
    loadValid = 1'b1;
    loadTarget = target;
    loadAddr = ADDR_BITS'(row * LANES + lane);
    loadData = data;
    #1;
    checkValue("loadReady", loadReady, 0);
  endtask

  task automatic startRequest(input int rw, input int rp);
    @(negedge clkA);
    loadValid = 1'b0;
    rowW = ROW_BITS'(rw);
    rowP = ROW_BITS'(rp);
    req = 1'b1;
    requestExpected = refDot(rw, rp);
    expectedQ.push_back(requestExpected);
  endtask

  task automatic finishRequest(input int hold);
    @(negedge clkA);
    loadValid = 1'b0;
    while (!ack) @(negedge clkA);
    repeat (hold) begin
      @(negedge clkA);
      checkValue("ack", ack, 1);                     // Back-pressure keeps ack up.
      checkValue("resultData", resultData, requestExpected);
    end
    req = 1'b0;
    @(negedge clkA);
    checkValue("ack", ack, 0);
  endtask

  task automatic runRequest(input int rw, input int rp, input int hold);
    startRequest(rw, rp);
    finishRequest(hold);
  endtask

  // ##########################################################################
  // Test sequence
  // ##########################################################################

  initial begin
    void'($urandom(32'h902a));
    arstN = 1'b0;
    loadValid = 1'b0;
    loadTarget = TARGET_WEIGHT;
    loadAddr = '0;
    loadData = '0;
    req = 1'b0;
    rowW = '0;
    rowP = '0;
    for (int row = 0; row < ROWS; row++) begin
      for (int lane = 0; lane < LANES; lane++) begin
        shadowW[row][lane] = '0;
        shadowP[row][lane] = '0;
      end
    end
    repeat (4) @(negedge clkA);
    arstN = 1'b1;
    @(negedge clkA);
    checkValue("loadReady", loadReady, 1);
    checkValue("ack", ack, 0);
    checkValue("resultData", resultData, 0);
    runRequest(0, 0, 0);                             // Unloaded rows give zero.

    for (int row = 0; row < ROWS; row++) begin
      for (int lane = 0; lane < LANES; lane++) begin
        writeLane(TARGET_WEIGHT, row, lane, LANE_BITS'($urandom_range(255, 0)));
        writeLane(TARGET_PIXEL, row, lane, LANE_BITS'($urandom_range(255, 0)));
      end
    end
    repeat (NUM_RANDOM_REQ) begin
      runRequest($urandom_range(ROWS - 1, 0), $urandom_range(ROWS - 1, 0),
                 $urandom_range(3, 0));
    end

    // Rows 14 and 15 hold the most negative and most positive sums.
    for (int lane = 0; lane < LANES; lane++) begin
      writeLane(TARGET_WEIGHT, 14, lane, 8'h80);
      writeLane(TARGET_PIXEL, 14, lane, 8'hff);
      writeLane(TARGET_WEIGHT, 15, lane, 8'h7f);
      writeLane(TARGET_PIXEL, 15, lane, 8'hff);
    end
    runRequest(14, 14, 0);
    runRequest(15, 15, 1);
    runRequest(14, 15, 0);

    runRequest(3, 5, 0);
    writeLane(TARGET_WEIGHT, 3, 2, LANE_BITS'($urandom_range(255, 0)));
    runRequest(3, 5, 0);

    startRequest(2, 9);
    offerLoad(TARGET_WEIGHT, 2, 0, 8'h5a);
    offerLoad(TARGET_WEIGHT, 2, 1, 8'ha5);
    offerLoad(TARGET_PIXEL, 9, 2, 8'h3c);
    offerLoad(TARGET_PIXEL, 9, 3, 8'hc3);
    finishRequest(0);
    runRequest(2, 9, 0);                             // Dropped loads must not show up.

    repeat (4) begin
      runRequest($urandom_range(ROWS - 1, 0), $urandom_range(ROWS - 1, 0),
                 $urandom_range(6, 2));
    end

    repeat (2) @(negedge clkA);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
dotPkg.sv
asymRamReadWide.sv
dotCombiner.sv
requestControl.sv
dotEngine.sv
dotEngineTb.sv

// File: Bender.yml
package:
  name: dotEngine

sources:
  - dotPkg.sv
  - asymRamReadWide.sv
  - dotCombiner.sv
  - requestControl.sv
  - dotEngine.sv
  - target: simulation
    files:
      - dotEngineTb.sv
